// ==== src.f ====
hdl/merge_pkg.sv
hdl/run_fifo.sv
hdl/merge_control.sv
hdl/merge_lane.sv
hdl/run_dispatch.sv
hdl/run_collect.sv
hdl/merge_sorter_top.sv
sim/tb_merge_sorter.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_merge_sorter \
   -f src.f -o tb_merge_sorter

./obj_dir/tb_merge_sorter | tee sim.log

if grep -qx "all tests passed" sim.log; then
   echo "Simulation PASS"
   exit 0
fi
echo "Simulation FAIL, see sim.log"
exit 1

// ==== sim/tb_merge_sorter.sv ====
module tb_merge_sorter;

   typedef logic [merge_pkg::DATA_W-1:0] key_t;

   logic                    clk = 1'b0;
   logic                    rst_n = 1'b0;
   merge_pkg::stream_beat_t in_beat = '0;
   logic                    in_ready;
   merge_pkg::stream_beat_t out_beat;
   logic                    out_ready = 1'b0;
   logic                    backpressure = 1'b0;
   logic                    in_stalled = 1'b0;

   // Words still to send, and the reference result still to come out.
   key_t in_q[$];
   key_t exp_q[$];
   key_t run_a[$];
   key_t run_b[$];
   key_t rec_in[$];
   key_t rec_exp[$];
   int   words_total = 0;
   int   limit = 200;
   int   cycles = 0;

   merge_sorter_top i_merge_sorter_top (
      .i_clk       (clk),
      .i_rst_n     (rst_n),
      .i_in        (in_beat),
      .o_in_ready  (in_ready),
      .o_out       (out_beat),
      .i_out_ready (out_ready)
   );

   always #4 clk = ~clk;

   task automatic fail_run(input string why);
      $display("tests failed");
      $fatal(1, "%s", why);
   endtask

   function automatic merge_pkg::stream_beat_t beat_of(input key_t k);
      merge_pkg::stream_beat_t b;
      b.valid = 1'b1;
      b.data  = k;
      return b;
   endfunction

   task automatic check_beat(input merge_pkg::stream_beat_t act,
                             input merge_pkg::stream_beat_t exp);
      if (act !== exp) begin
         $display("FAIL %0t: output got valid=%0b data=%h, expected valid=%0b data=%h",
                  $time, act.valid, act.data, exp.valid, exp.data);
         fail_run("output mismatch");
      end
   endtask

   task automatic compare_flag(input logic act, input logic exp, input string what);
      if (act !== exp) begin
         $display("FAIL %0t: %s is %0b, expected %0b", $time, what, act, exp);
         fail_run("flag mismatch");
      end
   endtask

   // Input driver; valid and data hold until the DUT takes the word.
   always @(posedge clk) begin
      if (rst_n) begin
         if (in_beat.valid && !in_ready) begin
            in_stalled <= 1'b1;
         end
         if (!in_beat.valid || in_ready) begin
            if (in_q.size() > 0) begin
               in_beat.data  <= in_q.pop_front();
               in_beat.valid <= 1'b1;
            end else begin
               in_beat.valid <= 1'b0;
            end
         end
         out_ready <= backpressure ? ($urandom_range(7, 0) == 0) : 1'b1;
      end
   end

   always @(posedge clk) begin
      if (rst_n && out_beat.valid && out_ready) begin
         if (exp_q.size() == 0) begin
            $display("Output word %h arrived with no result pending", out_beat.data);
            fail_run("extra output");
         end else begin
            check_beat(out_beat, beat_of(exp_q.pop_front()));
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > limit) begin
         $display("Timeout: the DUT did not finish within %0d cycles", limit);
         fail_run("timeout");
      end
   end

   task automatic add_budget(input int words);
      words_total += words;
      limit = 40 * words_total + 200;
   endtask

   // Queues both runs with their markers and the stable merge of the pair.
   task automatic queue_pair();
      int ia;
      int ib;
      ia = 0;
      ib = 0;
      foreach (run_a[i]) in_q.push_back(run_a[i]);
      in_q.push_back(merge_pkg::END_KEY);
      foreach (run_b[i]) in_q.push_back(run_b[i]);
      in_q.push_back(merge_pkg::END_KEY);
      while (ia < run_a.size() || ib < run_b.size()) begin
         if (ib >= run_b.size() || (ia < run_a.size() && run_a[ia] <= run_b[ib])) begin
            exp_q.push_back(run_a[ia]);
            ia++;
         end else begin
            exp_q.push_back(run_b[ib]);
            ib++;
         end
      end
      exp_q.push_back(merge_pkg::END_KEY);
      add_budget(run_a.size() + run_b.size() + 2);
   endtask

   // Sorted nonzero keys; a zero step gives repeated keys.
   task automatic random_runs(input int len_a, input int len_b);
      key_t k;
      run_a.delete();
      run_b.delete();
      k = key_t'($urandom_range(40, 1));
      for (int i = 0; i < len_a; i++) begin
         run_a.push_back(k);
         k = k + key_t'($urandom_range(6, 0));
      end
      k = key_t'($urandom_range(40, 1));
      for (int i = 0; i < len_b; i++) begin
         run_b.push_back(k);
         k = k + key_t'($urandom_range(6, 0));
      end
   endtask

   task automatic wait_drain();
      while (in_q.size() != 0 || exp_q.size() != 0) begin
         @(posedge clk);
      end
      repeat (4) @(posedge clk);
   endtask

   task automatic basic_and_tie_pairs();
      run_a = '{16'd3, 16'd10, 16'd20};
      run_b = '{16'd5, 16'd7, 16'd25, 16'd30};
      queue_pair();
      run_a = '{16'd4, 16'd4, 16'd9, 16'd9};
      run_b = '{16'd4, 16'd9, 16'd9, 16'd12};
      queue_pair();
      run_a = '{16'd1, 16'd2, 16'd3};
      run_b = '{16'd1, 16'd2, 16'd3};
      queue_pair();
      wait_drain();
   endtask

   task automatic empty_run_pairs();
      run_a.delete();
      run_b = '{16'd2, 16'd8};
      queue_pair();
      run_a = '{16'd6};
      run_b.delete();
      queue_pair();
      run_a.delete();
      queue_pair();
      wait_drain();
   endtask

   task automatic random_pair_order();
      for (int p = 0; p < 8; p++) begin
         random_runs($urandom_range(15, 0), $urandom_range(15, 0));
         queue_pair();
      end
      rec_in  = in_q;
      rec_exp = exp_q;
      wait_drain();
   endtask

   // Same stream again, now with a stalling consumer.
   task automatic stalled_output_replay();
      backpressure = 1'b1;
      in_q  = rec_in;
      exp_q = rec_exp;
      add_budget(rec_in.size());
      wait_drain();
   endtask

   // Long runs behind a slow consumer back up into the input.
   task automatic max_length_pairs();
      for (int p = 0; p < 5; p++) begin
         random_runs(15, 15);
         queue_pair();
      end
      wait_drain();
      compare_flag(in_stalled, 1'b1, "o_in_ready drop while input waited");
   endtask

   initial begin
      void'($urandom(32'h821));
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      compare_flag(in_ready, 1'b1, "o_in_ready after reset");
      compare_flag(out_beat.valid, 1'b0, "o_out.valid after reset");
      basic_and_tie_pairs();
      empty_run_pairs();
      random_pair_order();
      stalled_output_replay();
      max_length_pairs();
      $display("all tests passed");
      $finish;
   end

endmodule

// ==== hdl/merge_sorter_top.sv ====
module merge_sorter_top (
   input  logic                    i_clk,
   input  logic                    i_rst_n,
   input  merge_pkg::stream_beat_t i_in,
   output logic                    o_in_ready,
   output merge_pkg::stream_beat_t o_out,
   input  logic                    i_out_ready
);

   merge_pkg::stream_beat_t [merge_pkg::LANES-1:0] lane_beat;
   logic [merge_pkg::LANES-1:0]                    lane_side_b;
   logic [merge_pkg::LANES-1:0]                    lane_ready_a;
   logic [merge_pkg::LANES-1:0]                    lane_ready_b;
   merge_pkg::stream_beat_t [merge_pkg::LANES-1:0] lane_out;
   logic [merge_pkg::LANES-1:0]                    lane_out_ready;

   run_dispatch u_run_dispatch (
      .i_clk          (i_clk),
      .i_rst_n        (i_rst_n),
      .i_in           (i_in),
      .o_in_ready     (o_in_ready),
      .o_lane_beat    (lane_beat),
      .o_lane_side_b  (lane_side_b),
      .i_lane_ready_a (lane_ready_a),
      .i_lane_ready_b (lane_ready_b)
   );

   for (genvar g = 0; g < merge_pkg::LANES; g++) begin : g_lane
      merge_lane u_merge_lane (
         .i_clk       (i_clk),
         .i_rst_n     (i_rst_n),
         .i_beat      (lane_beat[g]),
         .i_side_b    (lane_side_b[g]),
         .o_ready_a   (lane_ready_a[g]),
         .o_ready_b   (lane_ready_b[g]),
         .o_out       (lane_out[g]),
         .i_out_ready (lane_out_ready[g])
      );
   end

   run_collect u_run_collect (
      .i_clk        (i_clk),
      .i_rst_n      (i_rst_n),
      .i_lane_beat  (lane_out),
      .o_lane_ready (lane_out_ready),
      .o_out        (o_out),
      .i_out_ready  (i_out_ready)
   );

endmodule

// ==== hdl/run_collect.sv ====
module run_collect (
   input  logic                                           i_clk,
   input  logic                                           i_rst_n,
   input  merge_pkg::stream_beat_t [merge_pkg::LANES-1:0] i_lane_beat,
   output logic [merge_pkg::LANES-1:0]                    o_lane_ready,
   output merge_pkg::stream_beat_t                        o_out,
   input  logic                                           i_out_ready
);

   logic [merge_pkg::LANE_W-1:0] lane_idx;
   logic                         out_end;

   assign o_out   = i_lane_beat[lane_idx];
   assign out_end = (o_out.data == merge_pkg::END_KEY);

   always_comb begin
      for (int l = 0; l < merge_pkg::LANES; l++) begin
         o_lane_ready[l] = i_out_ready && (int'(lane_idx) == l);
      end
   end

   // Move on once the whole merged run has left.
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         lane_idx <= '0;
      end else if (o_out.valid && i_out_ready && out_end) begin
         lane_idx <= lane_idx + 1'b1;
      end
   end

endmodule

// ==== hdl/run_dispatch.sv ====
module run_dispatch (
   input  logic                                           i_clk,
   input  logic                                           i_rst_n,
   input  merge_pkg::stream_beat_t                        i_in,
   output logic                                           o_in_ready,
   output merge_pkg::stream_beat_t [merge_pkg::LANES-1:0] o_lane_beat,
   output logic [merge_pkg::LANES-1:0]                    o_lane_side_b,
   input  logic [merge_pkg::LANES-1:0]                    i_lane_ready_a,
   input  logic [merge_pkg::LANES-1:0]                    i_lane_ready_b
);

   logic [merge_pkg::LANE_W-1:0] lane_idx;
   logic                         side_b;
   logic                         in_end;

   assign in_end = (i_in.data == merge_pkg::END_KEY);

   assign o_in_ready    = side_b ? i_lane_ready_b[lane_idx] : i_lane_ready_a[lane_idx];
   assign o_lane_side_b = {merge_pkg::LANES{side_b}};

   // Only the selected lane sees valid.
   always_comb begin
      for (int l = 0; l < merge_pkg::LANES; l++) begin
         o_lane_beat[l].valid = i_in.valid && (int'(lane_idx) == l);
         o_lane_beat[l].data  = i_in.data;
      end
   end

   // A run ends on the marker; the pair ends on the B marker.
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         lane_idx <= '0;
         side_b   <= 1'b0;
      end else if (i_in.valid && o_in_ready && in_end) begin
         side_b <= !side_b;
         if (side_b) begin
            lane_idx <= lane_idx + 1'b1;
         end
      end
   end

   a_in_hold: assert property (
      @(posedge i_clk) disable iff (!i_rst_n)
      i_in.valid && !o_in_ready |=> i_in.valid && $stable(i_in.data)
   ) else $error("run_dispatch: input beat dropped before transfer");

endmodule

// ==== hdl/merge_lane.sv ====
module merge_lane (
   input  logic                    i_clk,
   input  logic                    i_rst_n,
   input  merge_pkg::stream_beat_t i_beat,
   input  logic                    i_side_b,
   output logic                    o_ready_a,
   output logic                    o_ready_b,
   output merge_pkg::stream_beat_t o_out,
   input  logic                    i_out_ready
);

   logic [merge_pkg::DATA_W-1:0] a_head;
   logic [merge_pkg::DATA_W-1:0] b_head;
   logic                         a_full;
   logic                         b_full;
   logic                         a_empty;
   logic                         b_empty;
   logic                         push_a;
   logic                         push_b;
   logic                         pop_a;
   logic                         pop_b;
   logic                         load;
   logic                         sel_a;
   logic                         slot_free;
   merge_pkg::merge_flags_t      flags;
   logic                         out_valid;
   logic [merge_pkg::DATA_W-1:0] out_data;

   assign o_ready_a = !a_full;
   assign o_ready_b = !b_full;
   assign push_a    = i_beat.valid && !i_side_b && !a_full;
   assign push_b    = i_beat.valid && i_side_b && !b_full;

   run_fifo u_fifo_a (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_push  (push_a),
      .i_data  (i_beat.data),
      .o_full  (a_full),
      .i_pop   (pop_a),
      .o_head  (a_head),
      .o_empty (a_empty)
   );

   run_fifo u_fifo_b (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_push  (push_b),
      .i_data  (i_beat.data),
      .o_full  (b_full),
      .i_pop   (pop_b),
      .o_head  (b_head),
      .o_empty (b_empty)
   );

   assign flags.a_empty = a_empty;
   assign flags.b_empty = b_empty;
   assign flags.a_end   = !a_empty && (a_head == merge_pkg::END_KEY);
   assign flags.b_end   = !b_empty && (b_head == merge_pkg::END_KEY);
   assign flags.a_lte_b = (a_head <= b_head);

   // Slot frees up in the same cycle it is taken.
   assign slot_free = !out_valid || i_out_ready;

   merge_control u_merge_control (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_flags     (flags),
      .i_slot_free (slot_free),
      .o_pop_a     (pop_a),
      .o_pop_b     (pop_b),
      .o_load      (load),
      .o_sel_a     (sel_a)
   );

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         out_valid <= 1'b0;
      end else if (load) begin
         out_valid <= 1'b1;
      end else if (i_out_ready) begin
         out_valid <= 1'b0;
      end
   end

   // Both markers popped together close the merged run.
   always_ff @(posedge i_clk) begin
      if (load) begin
         out_data <= (pop_a && pop_b) ? merge_pkg::END_KEY : (sel_a ? a_head : b_head);
      end
   end

   assign o_out.valid = out_valid;
   assign o_out.data  = out_data;

   a_out_hold: assert property (
      @(posedge i_clk) disable iff (!i_rst_n)
      out_valid && !i_out_ready |=> out_valid && $stable(out_data)
   ) else $error("merge_lane: output beat changed while stalled");

endmodule

// ==== hdl/merge_control.sv ====
module merge_control (
   input  logic                    i_clk,
   input  logic                    i_rst_n,
   input  merge_pkg::merge_flags_t i_flags,
   input  logic                    i_slot_free,
   output logic                    o_pop_a,
   output logic                    o_pop_b,
   output logic                    o_load,
   output logic                    o_sel_a
);

   merge_pkg::merge_state_e state;
   merge_pkg::merge_state_e next_state;
   logic                    stall;

   // Missing head or busy output slot.
   assign stall = !i_slot_free
                | (((state == merge_pkg::ST_TOGGLE) || (state == merge_pkg::ST_NOMINAL)) &&
                   (i_flags.a_empty || i_flags.b_empty))
                | ((state == merge_pkg::ST_DONE_A) && i_flags.b_empty)
                | ((state == merge_pkg::ST_DONE_B) && i_flags.a_empty);

   always_comb begin
      next_state = state;
      o_pop_a    = 1'b0;
      o_pop_b    = 1'b0;
      o_sel_a    = 1'b1;
      case (state)
         merge_pkg::ST_TOGGLE: begin
            if (!i_flags.a_empty && !i_flags.b_empty) begin
               if (i_flags.a_end && i_flags.b_end) begin
                  // Two empty runs close at once.
                  o_pop_a = !stall;
                  o_pop_b = !stall;
               end else if (i_flags.a_end) begin
                  next_state = merge_pkg::ST_DONE_A;
               end else if (i_flags.b_end) begin
                  next_state = merge_pkg::ST_DONE_B;
               end else begin
                  next_state = merge_pkg::ST_NOMINAL;
               end
            end
         end
         merge_pkg::ST_NOMINAL: begin
            if (i_flags.a_end) begin
               next_state = merge_pkg::ST_DONE_A;
            end else if (i_flags.b_end) begin
               next_state = merge_pkg::ST_DONE_B;
            end else if (!stall) begin
               // Ties go to A.
               o_sel_a = i_flags.a_lte_b;
               o_pop_a = i_flags.a_lte_b;
               o_pop_b = !i_flags.a_lte_b;
            end
         end
         merge_pkg::ST_DONE_A: begin
            o_sel_a = 1'b0;
            if (!stall) begin
               o_pop_b = 1'b1;
               if (i_flags.b_end) begin
                  o_pop_a    = 1'b1;
                  next_state = merge_pkg::ST_TOGGLE;
               end
            end
         end
         merge_pkg::ST_DONE_B: begin
            if (!stall) begin
               o_pop_a = 1'b1;
               if (i_flags.a_end) begin
                  o_pop_b    = 1'b1;
                  next_state = merge_pkg::ST_TOGGLE;
               end
            end
         end
         default: begin
            next_state = merge_pkg::ST_TOGGLE;
         end
      endcase
   end

   assign o_load = o_pop_a | o_pop_b;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= merge_pkg::ST_TOGGLE;
      end else begin
         state <= next_state;
      end
   end

   a_no_empty_pop: assert property (
      @(posedge i_clk) disable iff (!i_rst_n)
      !((o_pop_a && i_flags.a_empty) || (o_pop_b && i_flags.b_empty))
   ) else $error("merge_control: pop from empty FIFO");

endmodule

// ==== hdl/run_fifo.sv ====
module run_fifo (
   input  logic                         i_clk,
   input  logic                         i_rst_n,
   input  logic                         i_push,
   input  logic [merge_pkg::DATA_W-1:0] i_data,
   output logic                         o_full,
   input  logic                         i_pop,
   output logic [merge_pkg::DATA_W-1:0] o_head,
   output logic                         o_empty
);

   logic [merge_pkg::DATA_W-1:0] mem [merge_pkg::FIFO_DEPTH];

   // Extra top bit tells a full FIFO from an empty one.
   logic [merge_pkg::FIFO_AW:0] wr_ptr;
   logic [merge_pkg::FIFO_AW:0] rd_ptr;

   assign o_empty = (wr_ptr == rd_ptr);
   assign o_full  = (wr_ptr[merge_pkg::FIFO_AW] != rd_ptr[merge_pkg::FIFO_AW]) &&
                    (wr_ptr[merge_pkg::FIFO_AW-1:0] == rd_ptr[merge_pkg::FIFO_AW-1:0]);

   // First word falls through to the head.
   assign o_head = mem[rd_ptr[merge_pkg::FIFO_AW-1:0]];

   always_ff @(posedge i_clk) begin
      if (i_push) begin
         mem[wr_ptr[merge_pkg::FIFO_AW-1:0]] <= i_data;
      end
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (i_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (i_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // The dispatcher must hold off while the run FIFO is full.
   a_no_push_full: assert property (
      @(posedge i_clk) disable iff (!i_rst_n)
      i_push |-> !o_full
   ) else $error("run_fifo: push while full");

endmodule

// ==== hdl/merge_pkg.sv ====
package merge_pkg;

   localparam int DATA_W     = 16;
   localparam int LANES      = 4;
   localparam int LANE_W     = 2;
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

   // Reserved key that closes every run.
   localparam logic [DATA_W-1:0] END_KEY = '0;

   typedef struct packed {
      logic              valid;
      logic [DATA_W-1:0] data;
   } stream_beat_t;

   // Head status of the two run FIFOs of one lane.
   typedef struct packed {
      logic a_empty;
      logic b_empty;
      logic a_end;
      logic b_end;
      logic a_lte_b;
   } merge_flags_t;

   typedef enum logic [1:0] {
      ST_TOGGLE  = 2'd0,
      ST_NOMINAL = 2'd1,
      ST_DONE_A  = 2'd2,
      ST_DONE_B  = 2'd3
   } merge_state_e;

endpackage
